/* flist.f */
+incdir+include
src/neurram_pkg.sv
src/host_reg_bank.sv
src/wupdate_pulse_gen.sv
src/array_mode_ctrl.sv
src/status_readback.sv
src/neurram_ctrl_top.sv
tests/neurram_ctrl_asserts.sv
tests/neurram_ctrl_tb.sv

/* include/neurram_params.svh */
//----------------------------------------
// board-fixed widths for the array control plane
// pulled in by the package and by any RTL file that sizes a port
//----------------------------------------

`ifndef NEURRAM_PARAMS_SVH
`define NEURRAM_PARAMS_SVH

//----------------------------------------
// host bus
//----------------------------------------

// one host data word, read or written
`define NEURRAM_DATA_W 32

// register address space, 8 codes with 5 in use
`define NEURRAM_REG_ADDR_W 3

//----------------------------------------
// weight update
//----------------------------------------

// programming pulse width in sys_clk cycles
`define NEURRAM_PULSE_W 16

`endif

/* src/array_mode_ctrl.sv */
//----------------------------------------
// mode arbitration for the array static pins
// pins and address are registered, one cycle behind the config words
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module array_mode_ctrl (
	input  wire                          sys_clk,
	input  wire                          arst_n_i,
	input  neurram_pkg::mode_cfg_t       mode_i,
	input  neurram_pkg::ext_ctrl_t       ext_i,
	input  neurram_pkg::array_addr_t     array_addr_cfg_i,
	output neurram_pkg::array_ctrl_t     array_ctrl_o,
	output neurram_pkg::array_addr_t     array_addr_o
);

	import neurram_pkg::*;

	array_ctrl_t ctrl_d;
	array_ctrl_t ctrl_q;
	array_addr_t addr_q;

	//----------------------------------------
	// mode rules
	//----------------------------------------

	always_comb begin
		ctrl_d = '0;

		// exclusive modes, lfsr wins over everything
		ctrl_d.inference_mode = mode_i.inference &&
			!(mode_i.ifat || mode_i.lfsr || mode_i.wupdate);
		ctrl_d.ifat_mode      = mode_i.ifat &&
			!(mode_i.inference || mode_i.lfsr || mode_i.wupdate);
		ctrl_d.lfsr_mode      = mode_i.lfsr;
		ctrl_d.wupdate_mode   = mode_i.wupdate &&
			!(mode_i.inference || mode_i.ifat || mode_i.lfsr);
		ctrl_d.forward        = mode_i.forward;

		// 3n driver on for any read mode unless disabled
		ctrl_d.ext_3n = (mode_i.inference || mode_i.ifat || mode_i.lfsr) && !ext_i.disable_3n;
		ctrl_d.ext_3n_bl_sel = ext_i.ext_3n_bl_sel;
		ctrl_d.ext_3n_sl_sel = ext_i.ext_3n_sl_sel;
		ctrl_d.ext_1n        = ext_i.ext_1n;
		ctrl_d.ext_1n_bl_sel = ext_i.ext_1n_bl_sel;
		ctrl_d.ext_1n_sl_sel = ext_i.ext_1n_sl_sel;

		// precharge follows raw mode bits, not the arbitrated ones
		ctrl_d.ext_precharge_bl = ext_i.precharge_bl || mode_i.ifat || mode_i.inference;
		ctrl_d.ext_precharge_sl = ext_i.precharge_sl || mode_i.ifat || mode_i.inference;

		ctrl_d.ext_inference_enable_bl = ext_i.inf_bl || ctrl_d.inference_mode ||
			ctrl_d.ifat_mode;
		ctrl_d.ext_inference_enable_sl = ext_i.inf_sl || ctrl_d.inference_mode ||
			ctrl_d.ifat_mode;
	end

	//----------------------------------------
	// output registers
	//----------------------------------------

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q <= '0; // all pins low out of reset
			addr_q <= '0;
		end else begin
			ctrl_q <= ctrl_d;
			addr_q <= array_addr_cfg_i;
		end
	end

	assign array_ctrl_o = ctrl_q;
	assign array_addr_o = addr_q;

endmodule

`default_nettype wire

/* src/host_reg_bank.sv */
//----------------------------------------
// host side config registers and trigger pulses
// writes land at the strobe edge, triggers leave one cycle later
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "neurram_params.svh"

module host_reg_bank (
	input  wire                          sys_clk,
	input  wire                          arst_n_i,
	// host write port
	input  wire                          wr_i,
	input  neurram_pkg::host_wr_t        wr_req_i,
	// host trigger port
	input  wire                          trig_i,
	input  neurram_pkg::trig_op_e        trig_op_i,
	// config words
	output neurram_pkg::mode_cfg_t       mode_o,
	output neurram_pkg::ext_ctrl_t       ext_o,
	output neurram_pkg::array_addr_t     array_addr_cfg_o,
	output logic [`NEURRAM_PULSE_W-1:0]  pulse_width_o,
	// one-cycle trigger pulses
	output logic                         program_start_o,
	output logic                         program_ack_o
);

	import neurram_pkg::*;

	mode_cfg_t                  mode_q;
	ext_ctrl_t                  ext_q;
	array_addr_t                addr_q;
	logic [`NEURRAM_PULSE_W-1:0] pw_q;
	logic                       start_q;
	logic                       ack_q;

	//----------------------------------------
	// config registers
	//----------------------------------------

	// words kept right-aligned, upper data bits dropped
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mode_q <= '0;
			ext_q  <= '0;
			addr_q <= '0;
			pw_q   <= '0;
		end else if (wr_i) begin
			case (wr_req_i.addr)
				REG_MODE:        mode_q <= mode_cfg_t'(wr_req_i.data[$bits(mode_cfg_t)-1:0]);
				REG_EXT:         ext_q  <= ext_ctrl_t'(wr_req_i.data[$bits(ext_ctrl_t)-1:0]);
				REG_ARRAY:       addr_q <= array_addr_t'(wr_req_i.data[$bits(array_addr_t)-1:0]);
				REG_PULSE_WIDTH: pw_q   <= wr_req_i.data[`NEURRAM_PULSE_W-1:0];
				default: ; // status and spare codes
			endcase
		end
	end

	//----------------------------------------
	// trigger decode
	//----------------------------------------

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			start_q <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			start_q <= trig_i && (trig_op_i == TRIG_PROGRAM);
			ack_q   <= trig_i && (trig_op_i == TRIG_PROGRAM_ACK);
		end
	end

	assign mode_o           = mode_q;
	assign ext_o            = ext_q;
	assign array_addr_cfg_o = addr_q;
	assign pulse_width_o    = pw_q;
	assign program_start_o  = start_q;
	assign program_ack_o    = ack_q;

endmodule

`default_nettype wire

/* src/neurram_ctrl_top.sv */
//----------------------------------------
// control plane top level for the array test board
// host regs, pulse generator, mode pins and readback
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "neurram_params.svh"

module neurram_ctrl_top (
	input  wire                          sys_clk,
	input  wire                          arst_n_i,
	input  wire                          wr_i,
	input  neurram_pkg::host_wr_t        wr_req_i,
	input  wire                          trig_i,
	input  neurram_pkg::trig_op_e        trig_op_i,
	input  wire                          rd_i,
	input  neurram_pkg::reg_addr_e       rd_addr_i,
	output logic [`NEURRAM_DATA_W-1:0]   rd_data_o,
	output logic                         rd_valid_o,
	output neurram_pkg::array_ctrl_t     array_ctrl_o,
	output neurram_pkg::array_addr_t     array_addr_o,
	output logic                         wupdate_pulse_o
);

	import neurram_pkg::*;

	mode_cfg_t                   mode;
	ext_ctrl_t                   ext;
	array_addr_t                 array_addr_cfg;
	logic [`NEURRAM_PULSE_W-1:0] pulse_width;
	logic                        program_start;
	logic                        program_ack;
	logic                        wup_busy;
	logic                        wup_done;

	//----------------------------------------
	// input side
	//----------------------------------------

	host_reg_bank reg_bank_i (
		.sys_clk          (sys_clk),
		.arst_n_i         (arst_n_i),
		.wr_i             (wr_i),
		.wr_req_i         (wr_req_i),
		.trig_i           (trig_i),
		.trig_op_i        (trig_op_i),
		.mode_o           (mode),
		.ext_o            (ext),
		.array_addr_cfg_o (array_addr_cfg),
		.pulse_width_o    (pulse_width),
		.program_start_o  (program_start),
		.program_ack_o    (program_ack)
	);

	//----------------------------------------
	// processing
	//----------------------------------------

	wupdate_pulse_gen pulse_gen_i (
		.sys_clk         (sys_clk),
		.arst_n_i        (arst_n_i),
		.program_start_i (program_start),
		.program_ack_i   (program_ack),
		.pulse_width_i   (pulse_width),
		.wupdate_pulse_o (wupdate_pulse_o),
		.busy_o          (wup_busy),
		.done_o          (wup_done)
	);

	array_mode_ctrl mode_ctrl_i (
		.sys_clk          (sys_clk),
		.arst_n_i         (arst_n_i),
		.mode_i           (mode),
		.ext_i            (ext),
		.array_addr_cfg_i (array_addr_cfg),
		.array_ctrl_o     (array_ctrl_o),
		.array_addr_o     (array_addr_o)
	);

	//----------------------------------------
	// output side
	//----------------------------------------

	status_readback readback_i (
		.sys_clk          (sys_clk),
		.arst_n_i         (arst_n_i),
		.rd_i             (rd_i),
		.rd_addr_i        (rd_addr_i),
		.mode_i           (mode),
		.ext_i            (ext),
		.array_addr_cfg_i (array_addr_cfg),
		.pulse_width_i    (pulse_width),
		.wup_busy_i       (wup_busy),
		.wup_done_i       (wup_done),
		.rd_data_o        (rd_data_o),
		.rd_valid_o       (rd_valid_o)
	);

endmodule

`default_nettype wire

/* src/neurram_pkg.sv */
//----------------------------------------
// shared types for the array control plane
// host access, config words and the array pin bundle
//----------------------------------------

`default_nettype none

`include "neurram_params.svh"

package neurram_pkg;

	typedef enum logic [`NEURRAM_REG_ADDR_W-1:0] {
		REG_MODE        = 'd0,
		REG_EXT         = 'd1,
		REG_ARRAY       = 'd2,
		REG_PULSE_WIDTH = 'd3,
		REG_STATUS      = 'd4 // read only
	} reg_addr_e;

	typedef enum logic [1:0] {
		TRIG_PROGRAM     = 2'd1,
		TRIG_PROGRAM_ACK = 2'd2,
		TRIG_NONE        = 2'd0
	} trig_op_e;

	typedef struct packed {
		reg_addr_e                  addr;
		logic [`NEURRAM_DATA_W-1:0] data;
	} host_wr_t;

	// operating mode word, inference in bit 0
	typedef struct packed {
		logic forward;
		logic wupdate;
		logic lfsr;
		logic ifat;
		logic inference;
	} mode_cfg_t;

	// manual overrides, disable_3n in bit 0
	typedef struct packed {
		logic turn_off_precharge;
		logic turn_on_wl;
		logic inf_sl;
		logic inf_bl;
		logic precharge_sl;
		logic precharge_bl;
		logic ext_1n_sl_sel;
		logic ext_1n_bl_sel;
		logic ext_1n;
		logic ext_3n_sl_sel;
		logic ext_3n_bl_sel;
		logic disable_3n;
	} ext_ctrl_t;

	// array address word, addr_local in the low byte
	typedef struct packed {
		logic       dec_enable_vert;
		logic       dec_enable_horz;
		logic [2:0] addr_vert;
		logic [2:0] addr_horz;
		logic [1:0] select_write_reg;
		logic [7:0] addr_local;
	} array_addr_t;

	// static control pins driven to the array
	typedef struct packed {
		logic ext_inference_enable_sl;
		logic ext_inference_enable_bl;
		logic ext_precharge_sl;
		logic ext_precharge_bl;
		logic ext_1n_sl_sel;
		logic ext_1n_bl_sel;
		logic ext_1n;
		logic ext_3n_sl_sel;
		logic ext_3n_bl_sel;
		logic ext_3n;
		logic forward;
		logic wupdate_mode;
		logic lfsr_mode;
		logic ifat_mode;
		logic inference_mode;
	} array_ctrl_t;

	typedef enum logic [1:0] {
		WUP_IDLE  = 2'd0,
		WUP_PULSE = 2'd1,
		WUP_DONE  = 2'd2
	} wup_state_e;

endpackage

`default_nettype wire

/* src/status_readback.sv */
//----------------------------------------
// host readback of config and status words
// fixed one cycle latency and back to back reads
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "neurram_params.svh"

module status_readback (
	input  wire                          sys_clk,
	input  wire                          arst_n_i,
	input  wire                          rd_i,
	input  neurram_pkg::reg_addr_e       rd_addr_i,
	input  neurram_pkg::mode_cfg_t       mode_i,
	input  neurram_pkg::ext_ctrl_t       ext_i,
	input  neurram_pkg::array_addr_t     array_addr_cfg_i,
	input  wire [`NEURRAM_PULSE_W-1:0]   pulse_width_i,
	input  wire                          wup_busy_i,
	input  wire                          wup_done_i,
	output logic [`NEURRAM_DATA_W-1:0]   rd_data_o,
	output logic                         rd_valid_o
);

	import neurram_pkg::*;

	logic [`NEURRAM_DATA_W-1:0] word_d;
	logic [`NEURRAM_DATA_W-1:0] data_q;
	logic                       valid_q;

	// right-aligned word select with zero fill
	always_comb begin
		word_d = '0;
		case (rd_addr_i)
			REG_MODE:        word_d[$bits(mode_cfg_t)-1:0]   = mode_i;
			REG_EXT:         word_d[$bits(ext_ctrl_t)-1:0]   = ext_i;
			REG_ARRAY:       word_d[$bits(array_addr_t)-1:0] = array_addr_cfg_i;
			REG_PULSE_WIDTH: word_d[`NEURRAM_PULSE_W-1:0]    = pulse_width_i;
			REG_STATUS:      word_d[1:0] = {wup_busy_i, wup_done_i};
			default: ; // spare codes read zero
		endcase
	end

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
			data_q  <= '0;
		end else begin
			valid_q <= rd_i;
			if (rd_i)
				data_q <= word_d;
		end
	end

	assign rd_data_o  = data_q;
	assign rd_valid_o = valid_q;

endmodule

`default_nettype wire

/* src/wupdate_pulse_gen.sv */
//----------------------------------------
// weight update programming pulse
// start loads the width, done waits for the host ack
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "neurram_params.svh"

module wupdate_pulse_gen (
	input  wire                         sys_clk,
	input  wire                         arst_n_i,
	input  wire                         program_start_i,
	input  wire                         program_ack_i,
	input  wire [`NEURRAM_PULSE_W-1:0]  pulse_width_i,
	output logic                        wupdate_pulse_o,
	output logic                        busy_o,
	output logic                        done_o
);

	import neurram_pkg::*;

	wup_state_e                  state_q;
	logic [`NEURRAM_PULSE_W-1:0] cnt_q; // cycles left after this one

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= WUP_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				WUP_IDLE: begin
					if (program_start_i) begin
						state_q <= WUP_PULSE;
						// zero width still gives one cycle
						cnt_q   <= (pulse_width_i == '0) ? '0 : pulse_width_i - 1'b1;
					end
				end
				WUP_PULSE: begin
					if (cnt_q == '0)
						state_q <= WUP_DONE;
					else
						cnt_q <= cnt_q - 1'b1;
				end
				WUP_DONE: begin
					if (program_ack_i)
						state_q <= WUP_IDLE; // host has seen done
				end
				default: state_q <= WUP_IDLE;
			endcase
		end
	end

	assign wupdate_pulse_o = (state_q == WUP_PULSE);
	assign busy_o          = (state_q == WUP_PULSE);
	assign done_o          = (state_q == WUP_DONE);

endmodule

`default_nettype wire

/* tests/neurram_ctrl_asserts.sv */
//----------------------------------------
// protocol assertions for the control plane top
// bound into every neurram_ctrl_top instance
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module neurram_ctrl_asserts (
	input  wire                       sys_clk,
	input  wire                       arst_n_i,
	input  wire                       rd_i,
	input  wire                       rd_valid_i,
	input  wire                       wupdate_pulse_i,
	input  wire                       wup_done_i,
	input  neurram_pkg::array_ctrl_t  array_ctrl_i
);

	int fail_count = 0;

	// read returns exactly one cycle later
	read_gives_valid: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		rd_i |=> rd_valid_i)
		else begin
			fail_count++;
			$error("rd_valid_o missing one cycle after rd_i");
		end
	no_stray_valid: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		!rd_i |=> !rd_valid_i)
		else begin
			fail_count++;
			$error("rd_valid_o high without a read strobe");
		end

	pulse_not_from_done: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		$rose(wupdate_pulse_i) |-> !$past(wup_done_i))
		else begin
			fail_count++;
			$error("programming pulse rose while done was set");
		end

	// exclusive operating modes
	one_mode: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		$onehot0({array_ctrl_i.inference_mode, array_ctrl_i.ifat_mode,
			array_ctrl_i.wupdate_mode}))
		else begin
			fail_count++;
			$error("more than one operating mode active");
		end

endmodule

bind neurram_ctrl_top neurram_ctrl_asserts asserts_i (
	.sys_clk         (sys_clk),
	.arst_n_i        (arst_n_i),
	.rd_i            (rd_i),
	.rd_valid_i      (rd_valid_o),
	.wupdate_pulse_i (wupdate_pulse_o),
	.wup_done_i      (wup_done),
	.array_ctrl_i    (array_ctrl_o)
);

`default_nettype wire

/* tests/neurram_ctrl_tb.sv */
//----------------------------------------
// testbench for the control plane top
// random host traffic checked against a cycle model
//----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "neurram_params.svh"

module neurram_ctrl_tb;

	import neurram_pkg::*;

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RW         = 24;
	localparam int N_PINS       = 16;
	localparam int N_PROG       = 4;
	localparam int MAX_WIDTH    = 40;
	localparam int WAIT_LIMIT   = 8;
	// rough cycle cost per test
	localparam int T1_CYCLES   = 24;
	localparam int T2_CYCLES   = N_RW * 6 + 8;
	localparam int T3_CYCLES   = N_PINS * 6;
	localparam int T4_CYCLES   = N_PROG * (MAX_WIDTH + 24);
	localparam int T5_CYCLES   = 3 * (MAX_WIDTH + 24);
	localparam int WATCHDOG_NS = (RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
		T4_CYCLES + T5_CYCLES + 200) * 2 * HALF_PERIOD;

	logic                        sys_clk;
	logic                        arst_n_i;
	logic                        wr_i;
	host_wr_t                    wr_req_i;
	logic                        trig_i;
	trig_op_e                    trig_op_i;
	logic                        rd_i;
	reg_addr_e                   rd_addr_i;
	logic [`NEURRAM_DATA_W-1:0]  rd_data_o;
	logic                        rd_valid_o;
	array_ctrl_t                 array_ctrl_o;
	array_addr_t                 array_addr_o;
	logic                        wupdate_pulse_o;

	// reference model state
	mode_cfg_t                   m_mode;
	ext_ctrl_t                   m_ext;
	array_addr_t                 m_addr_cfg;
	logic [`NEURRAM_PULSE_W-1:0] m_pw;
	logic                        m_start;
	logic                        m_ack;
	wup_state_e                  m_state;
	int                          m_left; // pulse cycles still to go
	array_ctrl_t                 m_ctrl;
	array_addr_t                 m_addr_pins;
	logic                        m_rd_valid;
	logic [`NEURRAM_DATA_W-1:0]  m_rd_data;

	integer seed;
	int     errors;
	int     checks;
	int     tests;
	int     test_err0;

	initial sys_clk = 1'b0;
	always #HALF_PERIOD sys_clk = ~sys_clk;

	neurram_ctrl_top dut_i (
		.sys_clk         (sys_clk),
		.arst_n_i        (arst_n_i),
		.wr_i            (wr_i),
		.wr_req_i        (wr_req_i),
		.trig_i          (trig_i),
		.trig_op_i       (trig_op_i),
		.rd_i            (rd_i),
		.rd_addr_i       (rd_addr_i),
		.rd_data_o       (rd_data_o),
		.rd_valid_o      (rd_valid_o),
		.array_ctrl_o    (array_ctrl_o),
		.array_addr_o    (array_addr_o),
		.wupdate_pulse_o (wupdate_pulse_o)
	);

	//----------------------------------------
	// reference model
	//----------------------------------------

	function automatic array_ctrl_t mode_rules(input mode_cfg_t m, input ext_ctrl_t e);
		array_ctrl_t c;
		c = '0;
		c.inference_mode = m.inference & ~(m.ifat | m.lfsr | m.wupdate);
		c.ifat_mode      = m.ifat & ~(m.inference | m.lfsr | m.wupdate);
		c.lfsr_mode      = m.lfsr;
		c.wupdate_mode   = m.wupdate & ~(m.inference | m.ifat | m.lfsr);
		c.forward        = m.forward;
		c.ext_3n         = (m.inference | m.ifat | m.lfsr) & ~e.disable_3n;
		c.ext_3n_bl_sel  = e.ext_3n_bl_sel;
		c.ext_3n_sl_sel  = e.ext_3n_sl_sel;
		c.ext_1n         = e.ext_1n;
		c.ext_1n_bl_sel  = e.ext_1n_bl_sel;
		c.ext_1n_sl_sel  = e.ext_1n_sl_sel;
		c.ext_precharge_bl = e.precharge_bl | m.ifat | m.inference;
		c.ext_precharge_sl = e.precharge_sl | m.ifat | m.inference;
		c.ext_inference_enable_bl = e.inf_bl | c.inference_mode | c.ifat_mode;
		c.ext_inference_enable_sl = e.inf_sl | c.inference_mode | c.ifat_mode;
		return c;
	endfunction

	function automatic logic [`NEURRAM_DATA_W-1:0] read_word(input reg_addr_e a);
		logic [`NEURRAM_DATA_W-1:0] w;
		w = '0;
		case (a)
			REG_MODE:        w[4:0]  = m_mode;
			REG_EXT:         w[11:0] = m_ext;
			REG_ARRAY:       w[17:0] = m_addr_cfg;
			REG_PULSE_WIDTH: w[15:0] = m_pw;
			REG_STATUS: begin
				w[0] = (m_state == WUP_DONE);
				w[1] = (m_state == WUP_PULSE);
			end
			default: ; // spare codes
		endcase
		return w;
	endfunction

	// models one rising edge with old values read before they are overwritten
	task model_edge;
		m_rd_valid = rd_i;
		if (rd_i)
			m_rd_data = read_word(rd_addr_i);
		m_ctrl      = mode_rules(m_mode, m_ext);
		m_addr_pins = m_addr_cfg;
		case (m_state)
			WUP_IDLE: if (m_start) begin
				m_state = WUP_PULSE;
				m_left  = (m_pw == 0) ? 1 : m_pw;
			end
			WUP_PULSE: begin
				m_left = m_left - 1;
				if (m_left == 0)
					m_state = WUP_DONE;
			end
			WUP_DONE: begin
				if (m_ack)
					m_state = WUP_IDLE;
			end
			default: ;
		endcase
		m_start = trig_i && (trig_op_i == TRIG_PROGRAM);
		m_ack   = trig_i && (trig_op_i == TRIG_PROGRAM_ACK);
		if (wr_i) begin
			case (wr_req_i.addr)
				REG_MODE:        m_mode     = mode_cfg_t'(wr_req_i.data[4:0]);
				REG_EXT:         m_ext      = ext_ctrl_t'(wr_req_i.data[11:0]);
				REG_ARRAY:       m_addr_cfg = array_addr_t'(wr_req_i.data[17:0]);
				REG_PULSE_WIDTH: m_pw       = wr_req_i.data[15:0];
				default: ; // read only or unused
			endcase
		end
	endtask

	//----------------------------------------
	// compare tasks
	//----------------------------------------

	task automatic check_ctrl(input array_ctrl_t got, input array_ctrl_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input array_addr_t got, input array_addr_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input logic [`NEURRAM_DATA_W-1:0] got,
		input logic [`NEURRAM_DATA_W-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pulse(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	//----------------------------------------
	// host access
	//----------------------------------------

	// on the falling edge step the model, compare and release strobes
	task tick;
		@(negedge sys_clk);
		model_edge();
		check_ctrl(array_ctrl_o, m_ctrl, "array_ctrl_o");
		check_addr(array_addr_o, m_addr_pins, "array_addr_o");
		check_pulse(wupdate_pulse_o, m_state == WUP_PULSE, "wupdate_pulse_o");
		if (m_rd_valid) begin
			if (rd_valid_o !== 1'b1) begin
				errors++;
				$display("read strobe before %0t ns got no rd_valid_o one cycle later", $time);
			end else begin
				check_word(rd_data_o, m_rd_data, "rd_data_o");
			end
		end else if (rd_valid_o !== 1'b0) begin
			errors++;
			$display("rd_valid_o was high at %0t ns without a read strobe", $time);
		end
		wr_i      = 1'b0;
		trig_i    = 1'b0;
		trig_op_i = TRIG_NONE;
		rd_i      = 1'b0;
	endtask

	task automatic write_reg(input reg_addr_e a, input logic [`NEURRAM_DATA_W-1:0] d);
		wr_i          = 1'b1;
		wr_req_i.addr = a;
		wr_req_i.data = d;
		tick();
	endtask

	// data is checked on the next tick
	task automatic read_reg(input reg_addr_e a);
		rd_i      = 1'b1;
		rd_addr_i = a;
		tick();
	endtask

	task automatic trigger(input trig_op_e op);
		trig_i    = 1'b1;
		trig_op_i = op;
		tick();
	endtask

	task automatic expect_status(input logic [`NEURRAM_DATA_W-1:0] exp, input string what);
		read_reg(REG_STATUS);
		tick();
		check_word(rd_data_o, exp, what);
	endtask

	task automatic program_and_measure(input int exp_w);
		int waited;
		int high;
		waited = 1;
		high   = 0;
		trigger(TRIG_PROGRAM);
		while (wupdate_pulse_o !== 1'b1 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (wupdate_pulse_o !== 1'b1) begin
			errors++;
			$display("no programming pulse within %0d cycles of the trigger, at %0t ns",
				WAIT_LIMIT, $time);
		end else begin
			check_word(waited, 2, "cycles from program trigger to pulse");
			while (wupdate_pulse_o === 1'b1 && high < MAX_WIDTH + WAIT_LIMIT) begin
				tick();
				high++;
			end
			check_word(high, exp_w, "pulse length in cycles");
		end
	endtask

	task automatic start_test;
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished, %0d errors", tests, name, errors - test_err0);
	endtask

	//----------------------------------------
	// test sequence
	//----------------------------------------

	initial begin
		logic [`NEURRAM_DATA_W-1:0] d;
		logic [2:0]                 code;
		int                         w;
		seed        = 32'h6cac;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		arst_n_i    = 1'b0;
		wr_i        = 1'b0;
		wr_req_i    = '0;
		trig_i      = 1'b0;
		trig_op_i   = TRIG_NONE;
		rd_i        = 1'b0;
		rd_addr_i   = REG_MODE;
		m_mode      = '0;
		m_ext       = '0;
		m_addr_cfg  = '0;
		m_pw        = '0;
		m_start     = 1'b0;
		m_ack       = 1'b0;
		m_state     = WUP_IDLE;
		m_left      = 0;
		m_ctrl      = '0;
		m_addr_pins = '0;
		m_rd_valid  = 1'b0;
		m_rd_data   = '0;
		repeat (RESET_CYCLES) @(negedge sys_clk);
		arst_n_i = 1'b1;

		start_test();
		check_ctrl(array_ctrl_o, '0, "array_ctrl_o after reset");
		check_addr(array_addr_o, '0, "array_addr_o after reset");
		check_pulse(wupdate_pulse_o, 1'b0, "wupdate_pulse_o after reset");
		check_pulse(rd_valid_o, 1'b0, "rd_valid_o after reset");
		for (int i = 0; i < 8; i++) begin
			read_reg(reg_addr_e'(i));
			tick();
			check_word(rd_data_o, '0, "register after reset");
		end
		end_test("reset state");

		start_test();
		write_reg(REG_STATUS, 32'hffff_ffff);
		expect_status('0, "status after a host write");
		for (int i = 0; i < N_RW; i++) begin
			code = $random(seed);
			d    = $random(seed);
			write_reg(reg_addr_e'(code), d);
			read_reg(reg_addr_e'(code));
			code = $random(seed);
			read_reg(reg_addr_e'(code)); // back to back
			tick();
		end
		end_test("register write and readback");

		start_test();
		for (int i = 0; i < N_PINS; i++) begin
			write_reg(REG_MODE, $random(seed));
			write_reg(REG_EXT, $random(seed));
			write_reg(REG_ARRAY, $random(seed));
			tick();
			tick();
		end
		end_test("mode rules and array pins");

		start_test();
		for (int k = 0; k < N_PROG; k++) begin
			w = (k == 0) ? 0 : {$random(seed)} % (MAX_WIDTH + 1);
			d = $random(seed);
			d[15:0] = w;
			write_reg(REG_PULSE_WIDTH, d);
			program_and_measure((w == 0) ? 1 : w);
			expect_status(32'h1, "status after pulse");
			trigger(TRIG_PROGRAM); // ignored while done is still set
			repeat (4) tick();
			expect_status(32'h1, "status after trigger while done");
			trigger(TRIG_PROGRAM_ACK);
			tick();
		end
		end_test("programming pulse");

		start_test();
		w = 4 + {$random(seed)} % 20;
		write_reg(REG_PULSE_WIDTH, w);
		trigger(TRIG_PROGRAM_ACK); // idle ack
		tick();
		expect_status('0, "status after idle ack");
		program_and_measure(w);
		expect_status(32'h1, "status before ack");
		trigger(TRIG_PROGRAM_ACK);
		tick();
		expect_status('0, "status after ack");
		program_and_measure(w);
		trigger(TRIG_PROGRAM_ACK);
		tick();
		trigger(TRIG_PROGRAM);
		tick();
		trigger(TRIG_PROGRAM_ACK); // pulse is running here
		for (int n = 0; n < MAX_WIDTH + WAIT_LIMIT && wupdate_pulse_o === 1'b1; n++)
			tick();
		expect_status(32'h1, "status after ack while busy");
		trigger(TRIG_PROGRAM_ACK);
		tick();
		expect_status('0, "status after final ack");
		end_test("acknowledge");

		errors = errors + dut_i.asserts_i.fail_count;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
